// File: Makefile
VERILATOR  ?= verilator
TOP        := dcache_tb
RTL_TOP    := dcache_top
FLIST      := flist.f
VFLAGS     := --binary --timing --assert
LINT_FLAGS := --lint-only --timing
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FLIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "sim failed" $(LOG) || [ $$status -ne 0 ]; then \
		echo "simulation reported a failure"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: flist.f
src/dcache_pkg.sv
src/dcache_ctrl_pkg.sv
src/sdp_ram.sv
src/beat_counter.sv
src/dcache_ways.sv
src/dcache_ctrl.sv
src/dcache_top.sv
sim/dcache_checker.sv
sim/dcache_tb.sv

// File: sim/dcache_checker.sv
`timescale 1ns/1ps

module dcache_checker (
    input logic                        clk,
    input logic                        rst,
    input dcache_ctrl_pkg::ctrl_state_t state,
    input logic                        req_ready,
    input logic                        resp_valid,
    input logic                        mem_cmd_valid,
    input logic                        mem_cmd_ready,
    input dcache_ctrl_pkg::mem_op_t    mem_cmd_op,
    input dcache_pkg::addr_t           mem_cmd_addr
);
    import dcache_ctrl_pkg::*;

    int unsigned fail_count = 0;

    // response is a one-cycle pulse
    resp_pulse: assert property (@(posedge clk) disable iff (rst)
        resp_valid |=> !resp_valid)
        else begin
            fail_count++;
            $error("resp_valid stayed high for more than one cycle");
        end

    cmd_hold: assert property (@(posedge clk) disable iff (rst)
        mem_cmd_valid && !mem_cmd_ready |=>
            mem_cmd_valid && $stable(mem_cmd_addr) && $stable(mem_cmd_op))
        else begin
            fail_count++;
            $error("memory command dropped or changed before ready");
        end

    ready_idle: assert property (@(posedge clk) disable iff (rst)
        state != IDLE |-> !req_ready)
        else begin
            fail_count++;
            $error("req_ready high outside IDLE");
        end

endmodule

// File: sim/dcache_tb.sv
`timescale 1ns/1ps

module dcache_tb;
    import dcache_pkg::*;
    import dcache_ctrl_pkg::*;

    localparam int ACCEPT_LIMIT = 20;
    localparam int RESP_LIMIT   = 400;

    typedef struct packed {
        logic  wr;
        addr_t addr;
        data_t wdata;
        strb_t strb;
        logic  exp_hit;
        data_t exp_data;
    } row_t;

    logic    clk;
    logic    rst;
    logic    req_valid;
    logic    req_ready;
    logic    req_write;
    addr_t   req_addr;
    data_t   req_wdata;
    strb_t   req_wstrb;
    logic    resp_valid;
    data_t   resp_rdata;
    logic    mem_cmd_valid;
    logic    mem_cmd_ready;
    mem_op_t mem_cmd_op;
    addr_t   mem_cmd_addr;
    logic    mem_wvalid;
    logic    mem_wready;
    data_t   mem_wdata;
    logic    mem_rvalid;
    data_t   mem_rdata;

    data_t mem_store [addr_t];
    data_t ref_mem [addr_t];
    row_t  rows [$];

    dcache_top #(
        .NUM_SETS (NUM_SETS)
    ) i_dcache_top (
        .clk           (clk),
        .rst           (rst),
        .req_valid     (req_valid),
        .req_ready     (req_ready),
        .req_write     (req_write),
        .req_addr      (req_addr),
        .req_wdata     (req_wdata),
        .req_wstrb     (req_wstrb),
        .resp_valid    (resp_valid),
        .resp_rdata    (resp_rdata),
        .mem_cmd_valid (mem_cmd_valid),
        .mem_cmd_ready (mem_cmd_ready),
        .mem_cmd_op    (mem_cmd_op),
        .mem_cmd_addr  (mem_cmd_addr),
        .mem_wvalid    (mem_wvalid),
        .mem_wready    (mem_wready),
        .mem_wdata     (mem_wdata),
        .mem_rvalid    (mem_rvalid),
        .mem_rdata     (mem_rdata)
    );

    bind dcache_ctrl dcache_checker i_dcache_checker (
        .clk           (clk),
        .rst           (rst),
        .state         (state),
        .req_ready     (req_ready),
        .resp_valid    (resp_valid),
        .mem_cmd_valid (mem_cmd_valid),
        .mem_cmd_ready (mem_cmd_ready),
        .mem_cmd_op    (mem_cmd_op),
        .mem_cmd_addr  (mem_cmd_addr)
    );

    // initial memory content, every address bit matters
    function automatic data_t word_pattern(addr_t a);
        return {a[15:0], a[31:16]} ^ (a * 32'h9E37_79B1);
    endfunction

    function automatic data_t mem_read(addr_t a);
        if (mem_store.exists(a)) begin
            return mem_store[a];
        end
        return word_pattern(a);
    endfunction

    function automatic data_t ref_read(addr_t a);
        if (ref_mem.exists(a)) begin
            return ref_mem[a];
        end
        return word_pattern(a);
    endfunction

    function automatic data_t merge_lanes(data_t old_word, data_t new_word, strb_t strb);
        data_t result;
        result = old_word;
        for (int l = 0; l < STRB_W; l++) begin
            if (strb[l]) begin
                result[l*8 +: 8] = new_word[l*8 +: 8];
            end
        end
        return result;
    endfunction

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1, "stopping at first error");
    endtask

    // expected load data comes from the reference memory in table order
    task automatic add_row(input logic wr, input addr_t addr, input data_t wdata,
                           input strb_t strb, input logic exp_hit);
        row_t row;
        row.wr       = wr;
        row.addr     = addr;
        row.wdata    = wdata;
        row.strb     = strb;
        row.exp_hit  = exp_hit;
        row.exp_data = ref_read(addr);
        if (wr) begin
            ref_mem[addr] = merge_lanes(ref_read(addr), wdata, strb);
        end
        rows.push_back(row);
    endtask

    task automatic check_data(input data_t got, input data_t exp, input int row);
        if (got !== exp) begin
            stop_run($sformatf("[FAIL] %0t: row %0d load data %h, expected %h",
                               $time, row, got, exp));
        end
    endtask

    task automatic check_latency(input int got, input logic exp_hit, input int row);
        if (exp_hit && got != 2) begin
            stop_run($sformatf("[FAIL] %0t: row %0d hit took %0d cycles, expected 2",
                               $time, row, got));
        end else if (!exp_hit && got <= 2) begin
            stop_run($sformatf("[FAIL] %0t: row %0d expected a miss, responded in %0d cycles",
                               $time, row, got));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string name);
        if (got !== exp) begin
            stop_run($sformatf("[FAIL] %0t: %s is %b, expected %b", $time, name, got, exp));
        end
    endtask

    task automatic run_request(input row_t row, output data_t rdata, output int lat);
        int n;
        req_valid <= 1'b1;
        req_write <= row.wr;
        req_addr  <= row.addr;
        req_wdata <= row.wdata;
        req_wstrb <= row.strb;
        n = 0;
        @(posedge clk);
        while (!req_ready) begin
            n++;
            if (n >= ACCEPT_LIMIT) begin
                stop_run("timeout: the cache did not accept a request");
            end
            @(posedge clk);
        end
        req_valid <= 1'b0;
        lat = 0;
        do begin
            @(posedge clk);
            lat++;
            if (lat > RESP_LIMIT) begin
                stop_run("timeout: no response from the cache");
            end
        end while (!resp_valid);
        rdata = resp_rdata;
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // memory model with random back-pressure
    initial begin
        addr_t wr_addr;
        addr_t rd_addr;
        int    wr_left;
        int    rd_left;
        void'($urandom(78721));
        mem_cmd_ready <= 1'b0;
        mem_wready    <= 1'b0;
        mem_rvalid    <= 1'b0;
        mem_rdata     <= '0;
        wr_addr = '0;
        rd_addr = '0;
        wr_left = 0;
        rd_left = 0;
        forever begin
            @(posedge clk);
            if (rst) begin
                mem_cmd_ready <= 1'b0;
                mem_wready    <= 1'b0;
                mem_rvalid    <= 1'b0;
                wr_left = 0;
                rd_left = 0;
            end else begin
                if (mem_wvalid && mem_wready) begin
                    if (wr_left == 0) begin
                        stop_run("write data arrived outside a write-back burst");
                    end
                    mem_store[wr_addr] = mem_wdata;
                    wr_addr += 4;
                    wr_left--;
                end
                if (mem_cmd_valid && mem_cmd_ready) begin
                    if (mem_cmd_addr[4:0] != 5'd0) begin
                        stop_run("memory command address is not block aligned");
                    end
                    if (mem_cmd_op == MEM_WRITE) begin
                        wr_addr = mem_cmd_addr;
                        wr_left = WORDS_PER_BLOCK;
                    end else begin
                        rd_addr = mem_cmd_addr;
                        rd_left = WORDS_PER_BLOCK;
                    end
                end
                // refill words on back-to-back cycles
                if (rd_left > 0) begin
                    mem_rvalid <= 1'b1;
                    mem_rdata  <= mem_read(rd_addr);
                    rd_addr += 4;
                    rd_left--;
                end else begin
                    mem_rvalid <= 1'b0;
                end
                mem_cmd_ready <= ($urandom_range(0, 3) == 0);
                mem_wready    <= ($urandom_range(0, 2) != 0);
            end
        end
    end

    initial begin
        data_t got;
        int    lat;
        rst       <= 1'b1;
        req_valid <= 1'b0;
        req_write <= 1'b0;
        req_addr  <= '0;
        req_wdata <= '0;
        req_wstrb <= '0;

        // single block, partial store merge
        add_row(1'b0, 32'h0000_1064, 32'h0, 4'h0, 1'b0);
        add_row(1'b0, 32'h0000_1068, 32'h0, 4'h0, 1'b1);
        add_row(1'b1, 32'h0000_1064, 32'hDEAD_BEEF, 4'b0101, 1'b1);
        add_row(1'b0, 32'h0000_1064, 32'h0, 4'h0, 1'b1);
        // set 9, dirty victim must reach memory
        add_row(1'b1, 32'h0000_2128, 32'h1234_5678, 4'b1111, 1'b0);
        add_row(1'b1, 32'h0000_213C, 32'hCAFE_F00D, 4'b0011, 1'b1);
        add_row(1'b0, 32'h0000_2920, 32'h0, 4'h0, 1'b0);
        add_row(1'b0, 32'h0000_3120, 32'h0, 4'h0, 1'b0);
        add_row(1'b0, 32'h0000_2128, 32'h0, 4'h0, 1'b0);
        add_row(1'b0, 32'h0000_213C, 32'h0, 4'h0, 1'b1);
        add_row(1'b0, 32'h0000_2124, 32'h0, 4'h0, 1'b1);
        // set 17, A B A C evicts B
        add_row(1'b0, 32'h0000_4220, 32'h0, 4'h0, 1'b0);
        add_row(1'b0, 32'h0000_4A20, 32'h0, 4'h0, 1'b0);
        add_row(1'b0, 32'h0000_4220, 32'h0, 4'h0, 1'b1);
        add_row(1'b0, 32'h0000_5220, 32'h0, 4'h0, 1'b0);
        add_row(1'b0, 32'h0000_4220, 32'h0, 4'h0, 1'b1);
        add_row(1'b0, 32'h0000_4A20, 32'h0, 4'h0, 1'b0);
        // store miss allocates and merges
        add_row(1'b1, 32'h0000_6344, 32'hA1B2_C3D4, 4'b1000, 1'b0);
        add_row(1'b0, 32'h0000_6344, 32'h0, 4'h0, 1'b1);
        add_row(1'b0, 32'h0000_6340, 32'h0, 4'h0, 1'b1);

        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check_flag(req_ready, 1'b1, "req_ready after reset");
        check_flag(resp_valid, 1'b0, "resp_valid after reset");
        check_flag(mem_cmd_valid, 1'b0, "mem_cmd_valid after reset");
        check_flag(mem_wvalid, 1'b0, "mem_wvalid after reset");

        foreach (rows[i]) begin
            run_request(rows[i], got, lat);
            if (!rows[i].wr) begin
                check_data(got, rows[i].exp_data, i);
            end
            check_latency(lat, rows[i].exp_hit, i);
        end

        if (i_dcache_top.i_dcache_ctrl.i_dcache_checker.fail_count == 0) begin
            $display("sim passed");
            $finish;
        end else begin
            $display("sim failed");
            $fatal(1, "handshake assertions failed");
        end
    end

endmodule

// File: src/beat_counter.sv
`timescale 1ns/1ps

module beat_counter #(
    parameter int BEATS = 8
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    input  logic                  step,
    output dcache_pkg::word_sel_t count,
    output logic                  last
);
    import dcache_pkg::*;

    localparam word_sel_t LAST_BEAT = word_sel_t'(BEATS - 1);

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (start) begin
            count <= '0;
        end else if (step) begin
            if (count == LAST_BEAT) begin
                count <= '0;
            end else begin
                count <= count + 1'b1;
            end
        end
    end

    assign last = (count == LAST_BEAT);

endmodule

// File: src/dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     req_valid,
    output logic                     req_ready,
    input  logic                     req_write,
    input  dcache_pkg::addr_t        req_addr,
    input  dcache_pkg::data_t        req_wdata,
    input  dcache_pkg::strb_t        req_wstrb,
    output logic                     resp_valid,
    output dcache_pkg::data_t        resp_rdata,
    output logic                     mem_cmd_valid,
    input  logic                     mem_cmd_ready,
    output dcache_ctrl_pkg::mem_op_t mem_cmd_op,
    output dcache_pkg::addr_t        mem_cmd_addr,
    output logic                     mem_wvalid,
    input  logic                     mem_wready,
    output dcache_pkg::data_t        mem_wdata,
    input  logic                     mem_rvalid,
    input  dcache_pkg::data_t        mem_rdata,
    output dcache_pkg::index_t       rd_index,
    output dcache_pkg::word_sel_t    rd_word,
    output dcache_pkg::tag_t         cmp_tag,
    input  logic                     hit,
    input  dcache_pkg::way_t         victim_way,
    input  logic                     victim_dirty,
    input  dcache_pkg::tag_t         victim_tag,
    input  dcache_pkg::data_t        rdata,
    input  dcache_pkg::data_t        victim_rdata,
    output logic                     fill_we,
    output dcache_pkg::way_t         fill_way,
    output dcache_pkg::tag_t         fill_tag,
    output dcache_pkg::word_sel_t    fill_word,
    output dcache_pkg::data_t        fill_data,
    output logic                     store_we,
    output dcache_pkg::strb_t        store_wstrb,
    output dcache_pkg::data_t        store_data,
    output logic                     touch,
    input  dcache_pkg::word_sel_t    count,
    input  logic                     last,
    output logic                     cnt_start,
    output logic                     cnt_step
);
    import dcache_pkg::*;
    import dcache_ctrl_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_next;
    logic        wbeat_fire;
    word_sel_t   wb_word;
    logic        write_q;
    tag_t        tag_q;
    index_t      index_q;
    word_sel_t   word_q;
    data_t       wdata_q;
    strb_t       wstrb_q;
    way_t        vic_way_q;
    tag_t        vic_tag_q;

    assign wbeat_fire = mem_wvalid && mem_wready;

    always_comb begin
        state_next = state;
        case (state)
            IDLE:      if (req_valid) state_next = LOOKUP;
            LOOKUP: begin
                if (hit) begin
                    state_next = RESP;
                end else if (victim_dirty) begin
                    state_next = WB_CMD;
                end else begin
                    state_next = FILL_CMD;
                end
            end
            WB_CMD:    if (mem_cmd_ready) state_next = WB_DATA;
            WB_DATA:   if (wbeat_fire && last) state_next = FILL_CMD;
            FILL_CMD:  if (mem_cmd_ready) state_next = FILL_DATA;
            FILL_DATA: if (mem_rvalid && last) state_next = RELOOK;
            RELOOK:    state_next = RESP;
            RESP:      state_next = IDLE;
            default:   state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            write_q <= req_write;
            tag_q   <= addr_tag(req_addr);
            index_q <= addr_index(req_addr);
            word_q  <= addr_word(req_addr);
            wdata_q <= req_wdata;
            wstrb_q <= req_wstrb;
        end
        if (state == LOOKUP) begin
            vic_way_q <= victim_way;
            vic_tag_q <= victim_tag;
        end
    end

    // next word is fetched on the accepting beat
    assign wb_word = wbeat_fire ? word_sel_t'(count + 1'b1) : count;

    always_comb begin
        if (state == IDLE) begin
            rd_index = addr_index(req_addr);
            rd_word  = addr_word(req_addr);
        end else if (state == WB_CMD || state == WB_DATA) begin
            rd_index = index_q;
            rd_word  = wb_word;
        end else begin
            rd_index = index_q;
            rd_word  = word_q;
        end
    end

    assign cmp_tag = tag_q;

    assign req_ready  = (state == IDLE);
    assign resp_valid = (state == RESP);
    assign resp_rdata = rdata;

    assign mem_cmd_valid = (state == WB_CMD) || (state == FILL_CMD);
    assign mem_cmd_op    = (state == WB_CMD) ? MEM_WRITE : MEM_READ;
    assign mem_cmd_addr  = (state == WB_CMD) ? block_addr(vic_tag_q, index_q)
                                             : block_addr(tag_q, index_q);
    assign mem_wvalid    = (state == WB_DATA);
    assign mem_wdata     = victim_rdata;

    assign cnt_start = (state == LOOKUP && !hit) || (wbeat_fire && last);
    assign cnt_step  = wbeat_fire || (state == FILL_DATA && mem_rvalid);

    // refill goes into the way chosen at lookup
    assign fill_we   = (state == FILL_DATA) && mem_rvalid;
    assign fill_way  = vic_way_q;
    assign fill_tag  = tag_q;
    assign fill_word = count;
    assign fill_data = mem_rdata;

    assign store_we    = (state == RESP) && write_q;
    assign store_wstrb = wstrb_q;
    assign store_data  = wdata_q;
    assign touch       = (state == RESP);

endmodule

// File: src/dcache_ctrl_pkg.sv
package dcache_ctrl_pkg;

    // controller states
    typedef enum logic [2:0] {
        IDLE      = 3'd0,
        LOOKUP    = 3'd1,
        WB_CMD    = 3'd2,
        WB_DATA   = 3'd3,
        FILL_CMD  = 3'd4,
        FILL_DATA = 3'd5,
        RELOOK    = 3'd6,
        RESP      = 3'd7
    } ctrl_state_t;

    // memory command kind
    typedef enum logic {
        MEM_READ  = 1'b0,
        MEM_WRITE = 1'b1
    } mem_op_t;

endpackage

// File: src/dcache_pkg.sv
package dcache_pkg;

    localparam int ADDR_W          = 32;
    localparam int DATA_W          = 32;
    localparam int WORDS_PER_BLOCK = 8;
    localparam int NUM_SETS        = 64;
    localparam int NUM_WAYS        = 2;

    localparam int BYTE_OFF_W = 2;
    localparam int STRB_W     = DATA_W / 8;
    localparam int OFFSET_W   = $clog2(WORDS_PER_BLOCK);
    localparam int INDEX_W    = $clog2(NUM_SETS);
    localparam int TAG_W      = ADDR_W - INDEX_W - OFFSET_W - BYTE_OFF_W;

    typedef logic [ADDR_W-1:0]           addr_t;
    typedef logic [DATA_W-1:0]           data_t;
    typedef logic [STRB_W-1:0]           strb_t;
    typedef logic [TAG_W-1:0]            tag_t;
    typedef logic [INDEX_W-1:0]          index_t;
    typedef logic [OFFSET_W-1:0]         word_sel_t;
    typedef logic [$clog2(NUM_WAYS)-1:0] way_t;

    // address fields, top to bottom: tag, index, word, byte
    function automatic tag_t addr_tag(addr_t addr);
        return addr[ADDR_W-1 -: TAG_W];
    endfunction

    function automatic index_t addr_index(addr_t addr);
        return addr[BYTE_OFF_W + OFFSET_W +: INDEX_W];
    endfunction

    function automatic word_sel_t addr_word(addr_t addr);
        return addr[BYTE_OFF_W +: OFFSET_W];
    endfunction

    function automatic addr_t block_addr(tag_t tag, index_t index);
        return {tag, index, {(OFFSET_W + BYTE_OFF_W){1'b0}}};
    endfunction

endpackage

// File: src/dcache_top.sv
`timescale 1ns/1ps

module dcache_top #(
    parameter int NUM_SETS = dcache_pkg::NUM_SETS
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     req_valid,
    output logic                     req_ready,
    input  logic                     req_write,
    input  dcache_pkg::addr_t        req_addr,
    input  dcache_pkg::data_t        req_wdata,
    input  dcache_pkg::strb_t        req_wstrb,
    output logic                     resp_valid,
    output dcache_pkg::data_t        resp_rdata,
    output logic                     mem_cmd_valid,
    input  logic                     mem_cmd_ready,
    output dcache_ctrl_pkg::mem_op_t mem_cmd_op,
    output dcache_pkg::addr_t        mem_cmd_addr,
    output logic                     mem_wvalid,
    input  logic                     mem_wready,
    output dcache_pkg::data_t        mem_wdata,
    input  logic                     mem_rvalid,
    input  dcache_pkg::data_t        mem_rdata
);
    import dcache_pkg::*;

    index_t    rd_index;
    word_sel_t rd_word;
    tag_t      cmp_tag;
    logic      hit;
    way_t      victim_way;
    logic      victim_dirty;
    tag_t      victim_tag;
    data_t     rdata;
    data_t     victim_rdata;
    logic      fill_we;
    way_t      fill_way;
    tag_t      fill_tag;
    word_sel_t fill_word;
    data_t     fill_data;
    logic      store_we;
    strb_t     store_wstrb;
    data_t     store_data;
    logic      touch;
    word_sel_t count;
    logic      last;
    logic      cnt_start;
    logic      cnt_step;

    dcache_ctrl i_dcache_ctrl (
        .clk           (clk),
        .rst           (rst),
        .req_valid     (req_valid),
        .req_ready     (req_ready),
        .req_write     (req_write),
        .req_addr      (req_addr),
        .req_wdata     (req_wdata),
        .req_wstrb     (req_wstrb),
        .resp_valid    (resp_valid),
        .resp_rdata    (resp_rdata),
        .mem_cmd_valid (mem_cmd_valid),
        .mem_cmd_ready (mem_cmd_ready),
        .mem_cmd_op    (mem_cmd_op),
        .mem_cmd_addr  (mem_cmd_addr),
        .mem_wvalid    (mem_wvalid),
        .mem_wready    (mem_wready),
        .mem_wdata     (mem_wdata),
        .mem_rvalid    (mem_rvalid),
        .mem_rdata     (mem_rdata),
        .rd_index      (rd_index),
        .rd_word       (rd_word),
        .cmp_tag       (cmp_tag),
        .hit           (hit),
        .victim_way    (victim_way),
        .victim_dirty  (victim_dirty),
        .victim_tag    (victim_tag),
        .rdata         (rdata),
        .victim_rdata  (victim_rdata),
        .fill_we       (fill_we),
        .fill_way      (fill_way),
        .fill_tag      (fill_tag),
        .fill_word     (fill_word),
        .fill_data     (fill_data),
        .store_we      (store_we),
        .store_wstrb   (store_wstrb),
        .store_data    (store_data),
        .touch         (touch),
        .count         (count),
        .last          (last),
        .cnt_start     (cnt_start),
        .cnt_step      (cnt_step)
    );

    beat_counter #(
        .BEATS (WORDS_PER_BLOCK)
    ) i_beat_counter (
        .clk   (clk),
        .rst   (rst),
        .start (cnt_start),
        .step  (cnt_step),
        .count (count),
        .last  (last)
    );

    // hit_way only steers writes inside the ways
    dcache_ways #(
        .NUM_SETS (NUM_SETS)
    ) i_dcache_ways (
        .clk          (clk),
        .rst          (rst),
        .rd_index     (rd_index),
        .rd_word      (rd_word),
        .cmp_tag      (cmp_tag),
        .hit          (hit),
        .hit_way      (),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .rdata        (rdata),
        .victim_rdata (victim_rdata),
        .fill_we      (fill_we),
        .fill_way     (fill_way),
        .fill_tag     (fill_tag),
        .fill_word    (fill_word),
        .fill_data    (fill_data),
        .store_we     (store_we),
        .store_wstrb  (store_wstrb),
        .store_data   (store_data),
        .touch        (touch)
    );

endmodule

// File: src/dcache_ways.sv
`timescale 1ns/1ps

module dcache_ways #(
    parameter int NUM_SETS = dcache_pkg::NUM_SETS
) (
    input  logic                  clk,
    input  logic                  rst,
    input  dcache_pkg::index_t    rd_index,
    input  dcache_pkg::word_sel_t rd_word,
    input  dcache_pkg::tag_t      cmp_tag,
    output logic                  hit,
    output dcache_pkg::way_t      hit_way,
    output dcache_pkg::way_t      victim_way,
    output logic                  victim_dirty,
    output dcache_pkg::tag_t      victim_tag,
    output dcache_pkg::data_t     rdata,
    output dcache_pkg::data_t     victim_rdata,
    input  logic                  fill_we,
    input  dcache_pkg::way_t      fill_way,
    input  dcache_pkg::tag_t      fill_tag,
    input  dcache_pkg::word_sel_t fill_word,
    input  dcache_pkg::data_t     fill_data,
    input  logic                  store_we,
    input  dcache_pkg::strb_t     store_wstrb,
    input  dcache_pkg::data_t     store_data,
    input  logic                  touch
);
    import dcache_pkg::*;

    localparam int DATA_DEPTH = NUM_SETS * WORDS_PER_BLOCK;
    localparam int DATA_AW    = $clog2(DATA_DEPTH);

    tag_t                              tag_rd [NUM_WAYS];
    data_t                             data_rd [NUM_WAYS];
    logic [NUM_WAYS-1:0]               way_hit;
    logic [NUM_WAYS-1:0][NUM_SETS-1:0] valid_q;
    logic [NUM_WAYS-1:0][NUM_SETS-1:0] dirty_q;
    index_t                            idx_q;
    way_t                              mru_way;
    logic                              fill_last;
    strb_t                             data_lanes;
    data_t                             data_wdata;
    logic [DATA_AW-1:0]                data_raddr;
    logic [DATA_AW-1:0]                data_waddr;

    assign fill_last  = (fill_word == word_sel_t'(WORDS_PER_BLOCK - 1));
    assign data_raddr = {rd_index, rd_word};
    assign data_waddr = fill_we ? {rd_index, fill_word} : {rd_index, rd_word};
    assign data_lanes = fill_we ? '1 : store_wstrb;
    assign data_wdata = fill_we ? fill_data : store_data;

    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        logic data_we;
        logic tag_we;

        assign data_we = (fill_we && fill_way == way_t'(w)) ||
                         (store_we && hit_way == way_t'(w));
        // tag goes in with the final refill word
        assign tag_we  = fill_we && fill_last && fill_way == way_t'(w);

        sdp_ram #(
            .entry_t (data_t),
            .DEPTH   (DATA_DEPTH),
            .LANES   (STRB_W)
        ) i_data_ram (
            .clk    (clk),
            .we     (data_we),
            .wlanes (data_lanes),
            .waddr  (data_waddr),
            .wdata  (data_wdata),
            .raddr  (data_raddr),
            .rdata  (data_rd[w])
        );

        sdp_ram #(
            .entry_t (tag_t),
            .DEPTH   (NUM_SETS),
            .LANES   (1)
        ) i_tag_ram (
            .clk    (clk),
            .we     (tag_we),
            .wlanes (1'b1),
            .waddr  (rd_index),
            .wdata  (fill_tag),
            .raddr  (rd_index),
            .rdata  (tag_rd[w])
        );

        assign way_hit[w] = valid_q[w][idx_q] && (tag_rd[w] == cmp_tag);
    end

    // one bit per set, holds the most recently used way
    sdp_ram #(
        .entry_t (way_t),
        .DEPTH   (NUM_SETS),
        .LANES   (1)
    ) i_lru_ram (
        .clk    (clk),
        .we     (touch),
        .wlanes (1'b1),
        .waddr  (rd_index),
        .wdata  (hit_way),
        .raddr  (rd_index),
        .rdata  (mru_way)
    );

    always_ff @(posedge clk) begin
        idx_q <= rd_index;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            if (fill_we && fill_last) begin
                valid_q[fill_way][rd_index] <= 1'b1;
                dirty_q[fill_way][rd_index] <= 1'b0;
            end
            if (store_we) begin
                dirty_q[hit_way][rd_index] <= 1'b1;
            end
        end
    end

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (way_hit[w]) begin
                hit_way = way_t'(w);
            end
        end
    end

    // lowest invalid way first, else the lru way
    always_comb begin
        victim_way = ~mru_way;
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (!valid_q[w][idx_q]) begin
                victim_way = way_t'(w);
            end
        end
    end

    assign hit          = |way_hit;
    assign rdata        = data_rd[hit_way];
    assign victim_rdata = data_rd[victim_way];
    assign victim_tag   = tag_rd[victim_way];
    assign victim_dirty = dirty_q[victim_way][idx_q];

endmodule

// File: src/sdp_ram.sv
`timescale 1ns/1ps

module sdp_ram #(
    parameter type entry_t = logic [31:0],
    parameter int  DEPTH   = 64,
    parameter int  LANES   = 1
) (
    input  logic                     clk,
    input  logic                     we,
    input  logic [LANES-1:0]         wlanes,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  entry_t                   wdata,
    input  logic [$clog2(DEPTH)-1:0] raddr,
    output entry_t                   rdata
);
    localparam int ENTRY_W = $bits(entry_t);
    localparam int LANE_W  = ENTRY_W / LANES;

    logic [ENTRY_W-1:0] mem [DEPTH];
    logic [ENTRY_W-1:0] wbits;

    assign wbits = wdata;

    // read returns old contents on a same-address write
    always_ff @(posedge clk) begin
        if (we) begin
            for (int l = 0; l < LANES; l++) begin
                if (wlanes[l]) begin
                    mem[waddr][l*LANE_W +: LANE_W] <= wbits[l*LANE_W +: LANE_W];
                end
            end
        end
        rdata <= entry_t'(mem[raddr]);
    end

endmodule
